// ==== all.f ====
design/ctrl_pkg.sv
design/player_if.sv
design/ps2_key_decoder.sv
design/input_merge.sv
design/dip_loader.sv
design/color_dac.sv
design/ctrl_top.sv
verif/ctrl_chk.sv
verif/tb_top.sv

// ==== Makefile ====
# Verilator flow for the cabinet input front end

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# Pass only when the pass line shows up on stdout
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_top.sv ====
// Cabinet front end testbench
module tb_top import ctrl_pkg::*; ();

	// ============================================================
	// Run constants
	// ============================================================
	localparam int CLK_PERIOD    = 100;
	localparam int DIP_BYTES     = 3;
	localparam int ADDR_W        = 25;
	localparam int N_RAND        = 20;
	localparam int unsigned SEED = 32'hca94_b842;
	// Cycles: reset, keys, pads, DIP writes, colour
	localparam int RUN_CYCLES    = 5 + 70 + (N_RAND + 1) + 7 + (16 + N_RAND);
	localparam int MARGIN_CYCLES = 100;

	logic                   CLK_49M;
	logic                   reset;
	logic [10:0]            ps2_key;
	joy_word_t              joy0;
	joy_word_t              joy1;
	logic                   dl_wr;
	logic [7:0]             dl_index;
	logic [ADDR_W-1:0]      dl_addr;
	logic [7:0]             dl_data;
	chan_in_t               r_in;
	chan_in_t               g_in;
	chan_in_t               b_in;
	logic [1:0]             coin;
	logic [1:0]             btn_start;
	logic [3:0]             p1_joystick;
	logic [3:0]             p2_joystick;
	logic                   p1_fire;
	logic                   p2_fire;
	logic                   btn_service;
	logic                   pause;
	logic [8*DIP_BYTES-1:0] dipsw;
	chan_out_t              r_out;
	chan_out_t              g_out;
	chan_out_t              b_out;
	logic [15:0]            cab_actual;

	// Reference state
	logic [15:0] held;
	logic [7:0]  key_code [16];
	logic [7:0]  dip_model [DIP_BYTES];
	logic [7:0]  dac_ref [16];
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	ctrl_top #(.DIP_BYTES(DIP_BYTES), .ADDR_W(ADDR_W)) dut_i (.*);

	bind ctrl_top ctrl_chk #(.DIP_BYTES(DIP_BYTES), .ADDR_W(ADDR_W)) chk_i (.CLK_49M, .reset,
		.dl_wr, .dl_index, .dl_addr, .coin, .btn_start, .p1_joystick, .p2_joystick,
		.p1_fire, .p2_fire, .btn_service, .pause, .dipsw, .r_out, .g_out, .b_out);

	// Cabinet outputs in one word
	assign cab_actual = {coin, btn_start, p1_joystick, p2_joystick,
		p1_fire, p2_fire, btn_service, pause};

	always #(CLK_PERIOD / 2) CLK_49M = ~CLK_49M;

	// ============================================================
	// Reference model and checks
	// ============================================================
	// Held key bits follow key_code order
	function automatic logic [15:0] cab_expected(input logic [15:0] k, input joy_word_t j0,
		input joy_word_t j1);
		logic [3:0] d1;
		logic [3:0] d2;
		// Order down up right left
		d1 = {k[7] | j0[JOY_DOWN], k[6] | j0[JOY_UP], k[9] | j0[JOY_RIGHT], k[8] | j0[JOY_LEFT]};
		d2 = {k[12] | j1[JOY_DOWN], k[11] | j1[JOY_UP], k[14] | j1[JOY_RIGHT],
			k[13] | j1[JOY_LEFT]};
		return {~k[3], ~(k[2] | j0[JOY_COIN] | j1[JOY_COIN]),
			~(k[1] | j1[JOY_START]), ~(k[0] | j0[JOY_START]), ~d1, ~d2,
			~(k[10] | j0[JOY_FIRE]), ~(k[15] | j1[JOY_FIRE]),
			k[4], k[5] | j0[JOY_PAUSE] | j1[JOY_PAUSE]};
	endfunction

	// Inverted bytes, highest first
	function automatic logic [8*DIP_BYTES-1:0] dip_expected();
		logic [8*DIP_BYTES-1:0] r;
		for (int i = 0; i < DIP_BYTES; i++)
			r[8*i +: 8] = ~dip_model[i];
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("%s: failed with %0d wrong values", name, test_errors);
		end else
			$display("%s: passed", name);
		errors += test_errors;
		test_errors = 0;
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_reset_state();
		// Active low high, service and pause low
		check_value("reset_state cabinet", 32'(16'hFFFC), 32'(cab_actual));
		check_value("reset_state dipsw", 32'(0), 32'(dipsw));
		check_value("reset_state colour", 32'(0), 32'({r_out, g_out, b_out}));
		finish_test("reset_state");
	endtask

	// Flip bit 10, then two cycles to the outputs
	task automatic key_event(input logic [7:0] code, input logic press);
		ps2_key = {~ps2_key[10], press, 1'b0, code};
		repeat (2) @(negedge CLK_49M);
	endtask

	task automatic test_keyboard();
		for (int i = 0; i < 16; i++) begin
			key_event(key_code[i], 1'b1);
			held[i] = 1'b1;
			check_value($sformatf("keyboard press %02h", key_code[i]),
				32'(cab_expected(held, joy0, joy1)), 32'(cab_actual));
			key_event(key_code[i], 1'b0);
			held[i] = 1'b0;
			check_value($sformatf("keyboard release %02h", key_code[i]),
				32'(cab_expected(held, joy0, joy1)), 32'(cab_actual));
		end
		// Enter is no cabinet key, up stays held
		key_event(key_code[6], 1'b1);
		held[6] = 1'b1;
		key_event(8'h5A, 1'b1);
		check_value("keyboard unknown", 32'(cab_expected(held, joy0, joy1)), 32'(cab_actual));
		key_event(key_code[6], 1'b0);
		held[6] = 1'b0;
		finish_test("keyboard");
	endtask

	task automatic test_joystick();
		for (int i = 0; i < N_RAND; i++) begin
			joy0 = 16'($urandom());
			joy1 = 16'($urandom());
			@(negedge CLK_49M);
			check_value("joystick", 32'(cab_expected(held, joy0, joy1)), 32'(cab_actual));
		end
		joy0 = '0;
		joy1 = '0;
		@(negedge CLK_49M);
		finish_test("joystick");
	endtask

	task automatic dip_write(input logic [7:0] index, input logic [ADDR_W-1:0] addr,
		input logic [7:0] data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		// Slot 254 and a stored byte only
		if (index == 8'd254 && addr < ADDR_W'(DIP_BYTES))
			dip_model[int'(addr)] = data;
		@(negedge CLK_49M);
		dl_wr = 1'b0;
		check_value($sformatf("dip index %0d addr %h", index, addr),
			32'(dip_expected()), 32'(dipsw));
	endtask

	task automatic test_dip();
		for (int i = 0; i < DIP_BYTES; i++)
			dip_write(8'd254, ADDR_W'(i), 8'($urandom()));
		// Writes that must be dropped
		dip_write(8'd253, '0, 8'h5A);
		dip_write(8'd254, ADDR_W'(3), 8'hA5);
		dip_write(8'd254, ADDR_W'(7), 8'h3C);
		dip_write(8'd254, 25'h100001, 8'hC3);
		finish_test("dip");
	endtask

	task automatic colour_step(input chan_in_t r, input chan_in_t g, input chan_in_t b);
		r_in = r;
		g_in = g;
		b_in = b;
		@(negedge CLK_49M);
		check_value("colour red", 32'(dac_ref[r]), 32'(r_out));
		check_value("colour green", 32'(dac_ref[g]), 32'(g_out));
		check_value("colour blue", 32'(dac_ref[b]), 32'(b_out));
	endtask

	task automatic test_colour();
		// Full sweep, green reversed, blue scrambled
		for (int v = 0; v < 16; v++)
			colour_step(4'(v), 4'(15 - v), 4'(v) ^ 4'h5);
		for (int i = 0; i < N_RAND; i++)
			colour_step(4'($urandom()), 4'($urandom()), 4'($urandom()));
		finish_test("colour");
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		void'($urandom(SEED));
		key_code = '{KEY_1, KEY_2, KEY_5, KEY_6, KEY_9, KEY_P, KEY_UP, KEY_DOWN,
			KEY_LEFT, KEY_RIGHT, KEY_CTRL, KEY_W, KEY_S, KEY_A, KEY_D, KEY_V};
		// Measured DAC levels
		dac_ref = '{8'd0, 8'd14, 8'd31, 8'd46, 8'd67, 8'd81, 8'd98, 8'd112,
			8'd143, 8'd157, 8'd174, 8'd188, 8'd209, 8'd224, 8'd241, 8'd255};
		for (int i = 0; i < DIP_BYTES; i++)
			dip_model[i] = 8'hFF;
		held         = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		CLK_49M      = 1'b0;
		reset        = 1'b1;
		ps2_key      = '0;
		joy0         = '0;
		joy1         = '0;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		r_in         = '0;
		g_in         = '0;
		b_in         = '0;
		repeat (4) @(negedge CLK_49M);
		reset = 1'b0;
		@(negedge CLK_49M);
		test_reset_state();
		test_keyboard();
		test_joystick();
		test_dip();
		test_colour();
		$display("Tests run %0d, tests failed %0d, wrong values %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
		$display("Watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== verif/ctrl_chk.sv ====
// Cabinet output assertions
module ctrl_chk import ctrl_pkg::*; #(
	parameter int DIP_BYTES = 3,
	parameter int ADDR_W    = 25
) (
	input logic                   CLK_49M,
	input logic                   reset,
	input logic                   dl_wr,
	input logic [7:0]             dl_index,
	input logic [ADDR_W-1:0]      dl_addr,
	input logic [1:0]             coin,
	input logic [1:0]             btn_start,
	input logic [3:0]             p1_joystick,
	input logic [3:0]             p2_joystick,
	input logic                   p1_fire,
	input logic                   p2_fire,
	input logic                   btn_service,
	input logic                   pause,
	input logic [8*DIP_BYTES-1:0] dipsw,
	input chan_out_t              r_out,
	input chan_out_t              g_out,
	input chan_out_t              b_out
);

	// Write lands in a stored byte
	logic dip_counted;

	assign dip_counted = dl_wr && dl_index == DIP_INDEX && dl_addr < ADDR_W'(DIP_BYTES);

	// No X once out of reset
	a_known: assert property (@(posedge CLK_49M) !reset |-> !$isunknown({coin, btn_start,
		p1_joystick, p2_joystick, p1_fire, p2_fire, btn_service, pause, dipsw,
		r_out, g_out, b_out}))
		else $error("cabinet output unknown after reset");

	// Switches hold without a counted write
	a_dip_hold: assert property (@(posedge CLK_49M) !reset && !dip_counted |=> $stable(dipsw))
		else $error("dipsw changed without a counted write");

	// All switches off after reset
	a_dip_reset: assert property (@(posedge CLK_49M) reset |=> dipsw == '0)
		else $error("dipsw not cleared by reset");

endmodule

// ==== design/ctrl_top.sv ====
// Cabinet input front end
module ctrl_top import ctrl_pkg::*; #(
	parameter int DIP_BYTES = 3,
	parameter int ADDR_W    = 25
) (
	input  logic                   CLK_49M,
	input  logic                   reset,
	// Keyboard and pads
	input  logic [10:0]            ps2_key,
	input  joy_word_t              joy0,
	input  joy_word_t              joy1,
	// Download port
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [ADDR_W-1:0]      dl_addr,
	input  logic [7:0]             dl_data,
	// Game colour
	input  chan_in_t               r_in,
	input  chan_in_t               g_in,
	input  chan_in_t               b_in,
	// Cabinet controls
	output logic [1:0]             coin,
	output logic [1:0]             btn_start,
	output logic [3:0]             p1_joystick,
	output logic [3:0]             p2_joystick,
	output logic                   p1_fire,
	output logic                   p2_fire,
	output logic                   btn_service,
	output logic                   pause,
	output logic [8*DIP_BYTES-1:0] dipsw,
	output chan_out_t              r_out,
	output chan_out_t              g_out,
	output chan_out_t              b_out
);

	// ============================================================
	// Keyboard to merge
	// ============================================================
	player_if kbd_p1 ();
	player_if kbd_p2 ();

	// System keys, plain wires
	logic service_key;
	logic pause_key;

	ps2_key_decoder u_keys (.CLK_49M, .reset, .ps2_key, .p1(kbd_p1), .p2(kbd_p2),
		.service(service_key), .pause_key);

	input_merge u_merge (.CLK_49M, .reset, .kbd1(kbd_p1), .kbd2(kbd_p2),
		.service(service_key), .pause_key, .joy0, .joy1, .coin, .btn_start,
		.p1_joystick, .p2_joystick, .p1_fire, .p2_fire, .btn_service, .pause);

	// ============================================================
	// DIP switches and colour
	// ============================================================
	dip_loader #(
		.DIP_BYTES(DIP_BYTES),
		.ADDR_W   (ADDR_W)
	) u_dip (.CLK_49M, .reset, .dl_wr, .dl_index, .dl_addr, .dl_data, .dipsw);

	// Widens 4-bit guns to 8 bits
	color_dac u_dac (.CLK_49M, .reset, .r_in, .g_in, .b_in, .r_out, .g_out, .b_out);

endmodule

// ==== design/color_dac.sv ====
// Resistor DAC colour lookup
module color_dac import ctrl_pkg::*; (
	input  logic      CLK_49M,
	input  logic      reset,
	input  chan_in_t  r_in,
	input  chan_in_t  g_in,
	input  chan_in_t  b_in,
	output chan_out_t r_out,
	output chan_out_t g_out,
	output chan_out_t b_out
);

	// One table for all three guns
	function automatic chan_out_t dac_level(input chan_in_t code);
		return DAC_TABLE[code];
	endfunction

	chan_out_t r_lvl;
	chan_out_t g_lvl;
	chan_out_t b_lvl;

	assign r_lvl = dac_level(r_in);
	assign g_lvl = dac_level(g_in);
	assign b_lvl = dac_level(b_in);

	// Output register, black in reset
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			r_out <= '0;
			g_out <= '0;
			b_out <= '0;
		end else begin
			r_out <= r_lvl;
			g_out <= g_lvl;
			b_out <= b_lvl;
		end
	end

endmodule

// ==== design/dip_loader.sv ====
// DIP switch byte store
module dip_loader import ctrl_pkg::*; #(
	parameter int DIP_BYTES = 3,
	parameter int ADDR_W    = 25
) (
	input  logic                   CLK_49M,
	input  logic                   reset,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [ADDR_W-1:0]      dl_addr,
	input  logic [7:0]             dl_data,
	output logic [8*DIP_BYTES-1:0] dipsw
);

	// Byte select wide enough for eight bytes
	localparam int SEL_W = 3;

	logic [7:0] dip_sw [DIP_BYTES];
	logic       dl_hit;

	// Right slot, low address window only
	assign dl_hit = dl_wr && dl_index == DIP_INDEX && dl_addr[ADDR_W-1:SEL_W] == '0;

	always_ff @(posedge CLK_49M) begin
		for (int i = 0; i < DIP_BYTES; i++) begin
			// Stored bytes are active low, all off
			if (reset)
				dip_sw[i] <= 8'hFF;
			else if (dl_hit && dl_addr[SEL_W-1:0] == SEL_W'(i))
				dip_sw[i] <= dl_data;
		end
	end

	// Highest byte in the top bits
	for (genvar g = 0; g < DIP_BYTES; g++) begin : g_dip
		assign dipsw[8*g +: 8] = ~dip_sw[g];
	end

endmodule

// ==== design/input_merge.sv ====
// Cabinet control merge
module input_merge import ctrl_pkg::*; (
	input  logic       CLK_49M,
	input  logic       reset,
	player_if.dst      kbd1,
	player_if.dst      kbd2,
	input  logic       service,
	input  logic       pause_key,
	input  joy_word_t  joy0,
	input  joy_word_t  joy1,
	output logic [1:0] coin,
	output logic [1:0] btn_start,
	output logic [3:0] p1_joystick,
	output logic [3:0] p2_joystick,
	output logic       p1_fire,
	output logic       p2_fire,
	output logic       btn_service,
	output logic       pause
);

	// Merged directions, cabinet order down up right left
	logic [3:0] p1_dir;
	logic [3:0] p2_dir;
	logic       coin_joy;
	logic       pause_joy;

	assign p1_dir = {kbd1.down | joy0[JOY_DOWN], kbd1.up | joy0[JOY_UP],
		kbd1.right | joy0[JOY_RIGHT], kbd1.left | joy0[JOY_LEFT]};
	assign p2_dir = {kbd2.down | joy1[JOY_DOWN], kbd2.up | joy1[JOY_UP],
		kbd2.right | joy1[JOY_RIGHT], kbd2.left | joy1[JOY_LEFT]};

	// Coin and pause accepted from either pad
	assign coin_joy  = joy0[JOY_COIN] | joy1[JOY_COIN];
	assign pause_joy = joy0[JOY_PAUSE] | joy1[JOY_PAUSE];

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			// Idle is high on the active-low lines
			coin        <= 2'b11;
			btn_start   <= 2'b11;
			p1_joystick <= 4'hF;
			p2_joystick <= 4'hF;
			p1_fire     <= 1'b1;
			p2_fire     <= 1'b1;
			btn_service <= 1'b0;
			pause       <= 1'b0;
		end else begin
			// Coin 2 only from the keyboard
			coin        <= ~{kbd2.coin, kbd1.coin | coin_joy};
			btn_start   <= ~{kbd2.start | joy1[JOY_START], kbd1.start | joy0[JOY_START]};
			p1_joystick <= ~p1_dir;
			p2_joystick <= ~p2_dir;
			p1_fire     <= ~(kbd1.fire | joy0[JOY_FIRE]);
			p2_fire     <= ~(kbd2.fire | joy1[JOY_FIRE]);
			// Service and pause stay active high
			btn_service <= service;
			pause       <= pause_key | pause_joy;
		end
	end

endmodule

// ==== design/ps2_key_decoder.sv ====
// PS/2 keyboard button decoder
module ps2_key_decoder import ctrl_pkg::*; (
	input  logic        CLK_49M,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	player_if.src       p1,
	player_if.src       p2,
	output logic        service,
	output logic        pause_key
);

	// Key event fields
	logic       toggle_q;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	// Bit 10 flips once per make or break
	assign key_event = ps2_key[10] != toggle_q;
	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];

	always_ff @(posedge CLK_49M) begin
		// Registered copy of the event toggle
		toggle_q <= ps2_key[10];
		if (reset) begin
			// All keys released
			p1.up    <= 1'b0;
			p1.down  <= 1'b0;
			p1.left  <= 1'b0;
			p1.right <= 1'b0;
			p1.fire  <= 1'b0;
			p1.start <= 1'b0;
			p1.coin  <= 1'b0;
			p2.up    <= 1'b0;
			p2.down  <= 1'b0;
			p2.left  <= 1'b0;
			p2.right <= 1'b0;
			p2.fire  <= 1'b0;
			p2.start <= 1'b0;
			p2.coin  <= 1'b0;
			service   <= 1'b0;
			pause_key <= 1'b0;
		end else if (key_event) begin
			case (code)
				// System keys
				KEY_1:     p1.start  <= pressed;
				KEY_2:     p2.start  <= pressed;
				KEY_5:     p1.coin   <= pressed;
				KEY_6:     p2.coin   <= pressed;
				KEY_9:     service   <= pressed;
				KEY_P:     pause_key <= pressed;
				// Player 1 block
				KEY_UP:    p1.up     <= pressed;
				KEY_DOWN:  p1.down   <= pressed;
				KEY_LEFT:  p1.left   <= pressed;
				KEY_RIGHT: p1.right  <= pressed;
				KEY_CTRL:  p1.fire   <= pressed;
				// Player 2 block
				KEY_W:     p2.up     <= pressed;
				KEY_S:     p2.down   <= pressed;
				KEY_A:     p2.left   <= pressed;
				KEY_D:     p2.right  <= pressed;
				KEY_V:     p2.fire   <= pressed;
				// Unknown code leaves held keys alone
				default: ;
			endcase
		end
	end

endmodule

// ==== design/player_if.sv ====
// Player control bundle
interface player_if;

	// Held controls, active high
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic start;
	logic coin;

	// Keyboard decoder side
	modport src (
		output up, down, left, right, fire, start, coin
	);

	// Merge side
	modport dst (
		input up, down, left, right, fire, start, coin
	);

endinterface

// ==== design/ctrl_pkg.sv ====
// Cabinet control definitions
package ctrl_pkg;

	// ============================================================
	// PS/2 set 2 scan codes
	// ============================================================
	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1E;
	localparam logic [7:0] KEY_5     = 8'h2E;
	localparam logic [7:0] KEY_6     = 8'h36;
	localparam logic [7:0] KEY_9     = 8'h46;
	localparam logic [7:0] KEY_P     = 8'h4D;
	// Arrows and ctrl for player 1
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_CTRL  = 8'h14;
	// WASD and v for player 2
	localparam logic [7:0] KEY_W     = 8'h1D;
	localparam logic [7:0] KEY_S     = 8'h1B;
	localparam logic [7:0] KEY_A     = 8'h1C;
	localparam logic [7:0] KEY_D     = 8'h23;
	localparam logic [7:0] KEY_V     = 8'h2A;

	// ============================================================
	// USB joystick word
	// ============================================================
	typedef logic [15:0] joy_word_t;

	// Bit positions, active high
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_START = 5;
	localparam int JOY_COIN  = 6;
	localparam int JOY_PAUSE = 7;

	// Download slot of the DIP switch bytes
	localparam logic [7:0] DIP_INDEX = 8'd254;

	// ============================================================
	// Colour channels
	// ============================================================
	typedef logic [3:0] chan_in_t;
	typedef logic [7:0] chan_out_t;

	// Measured levels of the weighted resistor DAC, entry 0 first
	localparam logic [0:15][7:0] DAC_TABLE = {
		8'd0,   8'd14,  8'd31,  8'd46,
		8'd67,  8'd81,  8'd98,  8'd112,
		8'd143, 8'd157, 8'd174, 8'd188,
		8'd209, 8'd224, 8'd241, 8'd255
	};

endpackage
